//--- rtl/task_unit_cfg.svh
// queue sizing and field widths; TTYPE_W must be wide enough to index N_TASK_TYPES ports
`ifndef TASK_UNIT_CFG_SVH
`define TASK_UNIT_CFG_SVH

// log2 of (slot count + 1)
`define TQ_STAGES 4

// usable slots, one index value is left over as the scan end marker
`define TQ_SLOTS ((1 << `TQ_STAGES) - 1)

// one read port per task type
`define N_TASK_TYPES 2

// task field widths
`define TS_W 16
`define HINT_W 16
`define TTYPE_W 1

`endif

//--- rtl/swarm_pkg.sv
// task, slot and store request types; field widths come from task_unit_cfg.svh
`default_nettype none

`include "task_unit_cfg.svh"

package swarm;

   // one queue entry as held in the slot memory
   typedef struct packed {
      logic [`TTYPE_W-1:0] ttype;
      logic [`TS_W-1:0]    ts;
      logic [`HINT_W-1:0]  hint;
   } task_t;

   // element on the producer write port, same layout as task_t
   typedef struct packed {
      logic [`TTYPE_W-1:0] ttype;
      logic [`TS_W-1:0]    ts;
      logic [`HINT_W-1:0]  hint;
   } tq_elem_s;

   // slot index, the all-ones value is never a real slot
   typedef logic [`TQ_STAGES-1:0] slot_t;

   // single engine request towards the shared store
   typedef struct packed {
      logic  en;
      logic  we;
      slot_t addr;
      task_t wdata;
   } mem_req_s;

endpackage

`default_nettype wire

//--- rtl/task_store_arbiter.sv
// single-port slot store shared by two engines; enqueue always wins, reads return after one cycle
`timescale 1ns/100ps
`default_nettype none

`include "task_unit_cfg.svh"

module task_store_arbiter (
   input  logic                 clk,
   input  logic                 reset,
   input  swarm::mem_req_s      enq_req,
   input  swarm::mem_req_s      scan_req,
   input  logic                 free_en,
   input  swarm::slot_t         free_slot,
   output logic                 enq_grant,
   output logic                 scan_grant,
   output swarm::task_t         rdata,
   output logic [`TQ_SLOTS-1:0] occupancy
);

   // request that owns the memory port this cycle
   swarm::mem_req_s sel_req;
   logic            port_en;
   logic            port_wr;

   // slot array, contents are only meaningful where occupancy is set
   swarm::task_t    mem [`TQ_SLOTS];

   // fixed priority, enqueue first
   assign enq_grant  = enq_req.en;
   assign scan_grant = scan_req.en & ~enq_req.en;

   always_comb begin
      if (enq_req.en) begin
         sel_req = enq_req;
      end else begin
         sel_req = scan_req;
      end
   end

   assign port_en = enq_req.en | scan_req.en;
   assign port_wr = port_en & sel_req.we;

   // memory port, write or registered read
   always_ff @(posedge clk) begin
      if (port_wr) begin
         mem[sel_req.addr] <= sel_req.wdata;
      end else if (port_en) begin
         rdata <= mem[sel_req.addr];
      end
   end

   // occupancy bitmap
   // a free and a write never target the same cycle in practice
   // but the write is applied last so a new task is never lost
   always_ff @(posedge clk) begin
      if (reset) begin
         occupancy <= '0;
      end else begin
         if (free_en) begin
            occupancy[free_slot] <= 1'b0;
         end
         if (port_wr) begin
            occupancy[sel_req.addr] <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/task_enqueue.sv
// write port engine; one accepted task is written to the lowest free slot on the following edge
`timescale 1ns/100ps
`default_nettype none

`include "task_unit_cfg.svh"

module task_enqueue (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 s_wvalid,
   output logic                 s_wready,
   input  swarm::tq_elem_s      s_wdata,
   input  logic [`TQ_SLOTS-1:0] occupancy,
   input  logic                 hold,
   output swarm::mem_req_s      enq_req,
   input  logic                 enq_grant,
   output logic                 enq_done
);

   // pending write towards the store
   logic                 wr_pend;
   swarm::slot_t         wr_slot;
   swarm::task_t         wr_data;

   // free slot search
   logic [`TQ_SLOTS-1:0] pend_mask;
   logic [`TQ_SLOTS-1:0] free_mask;
   logic                 free_found;
   swarm::slot_t         free_idx;

   // low during reset, high from the first edge after it
   logic                 run;
   logic                 accept;

   // slot of a write still in flight counts as taken
   assign pend_mask = wr_pend ? (`TQ_SLOTS'(1) << wr_slot) : '0;
   assign free_mask = ~occupancy & ~pend_mask;

   // priority encoder, lowest index wins
   always_comb begin
      free_found = 1'b0;
      free_idx   = '0;
      for (int i = `TQ_SLOTS - 1; i >= 0; i--) begin
         if (free_mask[i]) begin
            free_found = 1'b1;
            free_idx   = swarm::slot_t'(i);
         end
      end
   end

   // the previous write has to leave before a new one is taken
   assign s_wready = run & free_found & ~hold & (~wr_pend | enq_grant);
   assign accept   = s_wvalid & s_wready;

   always_ff @(posedge clk) begin
      if (reset) begin
         run     <= 1'b0;
         wr_pend <= 1'b0;
      end else begin
         run <= 1'b1;
         if (accept) begin
            wr_pend <= 1'b1;
         end else if (enq_grant) begin
            wr_pend <= 1'b0;
         end
      end
   end

   // captured task and its slot
   always_ff @(posedge clk) begin
      if (accept) begin
         wr_slot       <= free_idx;
         wr_data.ttype <= s_wdata.ttype;
         wr_data.ts    <= s_wdata.ts;
         wr_data.hint  <= s_wdata.hint;
      end
   end

   assign enq_req.en    = wr_pend;
   assign enq_req.we    = 1'b1;
   assign enq_req.addr  = wr_slot;
   assign enq_req.wdata = wr_data;

   // occupancy changes on this edge, scan restarts after it
   assign enq_done = wr_pend & enq_grant;

endmodule

`default_nettype wire

//--- rtl/task_min_scan.sv
// linear minimum scan over all slots; the winner blocks every read port until its own port takes it
`timescale 1ns/100ps
`default_nettype none

`include "task_unit_cfg.svh"

module task_min_scan (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic [`TQ_SLOTS-1:0]                 occupancy,
   input  logic                                 enq_done,
   output swarm::mem_req_s                      scan_req,
   input  logic                                 scan_grant,
   input  swarm::task_t                         rdata,
   output logic                                 free_en,
   output swarm::slot_t                         free_slot,
   output logic                                 hold,
   output logic [0:`N_TASK_TYPES-1]             m_rvalid,
   input  logic [0:`N_TASK_TYPES-1]             m_rready,
   output swarm::task_t [0:`N_TASK_TYPES-1]     m_rdata
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_SCAN,
      S_COMPARE,
      S_PRESENT
   } scan_state_e;

   scan_state_e  state;

   // next slot to read, reaches TQ_SLOTS once every slot was requested
   swarm::slot_t rd_idx;
   // read data for rd_slot shows up on rdata this cycle
   logic         rd_pend;
   swarm::slot_t rd_slot;

   // running minimum
   logic         best_valid;
   swarm::task_t best_task;
   swarm::slot_t best_slot;

   logic         scan_active;
   logic         rd_fire;
   logic         take;
   logic         restart;
   logic         present;

   // no reads at all when the queue is empty
   assign scan_active = (state == S_SCAN) & (|occupancy) &
                        (rd_idx != swarm::slot_t'(`TQ_SLOTS));

   assign scan_req.en    = scan_active;
   assign scan_req.we    = 1'b0;
   assign scan_req.addr  = rd_idx;
   assign scan_req.wdata = '0;

   // a refused read is simply issued again next cycle
   assign rd_fire = scan_req.en & scan_grant;

   // strictly smaller only, so the lower slot keeps a tie
   assign take = rd_pend & occupancy[rd_slot] &
                 (~best_valid | (rdata.ts < best_task.ts));

   // any change to occupancy throws the partial result away
   assign restart = enq_done | free_en;

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= S_IDLE;
         rd_idx     <= '0;
         rd_pend    <= 1'b0;
         best_valid <= 1'b0;
      end else if (restart) begin
         state      <= S_SCAN;
         rd_idx     <= '0;
         rd_pend    <= 1'b0;
         best_valid <= 1'b0;
      end else begin
         rd_pend <= rd_fire;
         if (rd_fire) begin
            rd_idx <= rd_idx + 1'b1;
         end
         if (take) begin
            best_valid <= 1'b1;
         end
         case (state)
            S_SCAN: begin
               // last read data is compared in the same cycle
               if (occupancy == '0) begin
                  state <= S_IDLE;
               end else if (rd_idx == swarm::slot_t'(`TQ_SLOTS)) begin
                  state <= S_COMPARE;
               end
            end
            S_COMPARE: begin
               state <= best_valid ? S_PRESENT : S_IDLE;
            end
            default: begin
               // idle waits for a restart, present leaves through free_en
            end
         endcase
      end
   end

   // slot tag of the returning read and the winner payload
   always_ff @(posedge clk) begin
      rd_slot <= rd_idx;
      if (take) begin
         best_task <= rdata;
         best_slot <= rd_slot;
      end
   end

   assign present = (state == S_PRESENT);

   // queue stays frozen from compare until the winner is taken
   assign hold = (state == S_COMPARE) | present;

   // route the winner to the port of its type
   for (genvar i = 0; i < `N_TASK_TYPES; i++) begin : g_port
      assign m_rvalid[i] = present & (best_task.ttype == `TTYPE_W'(i));
      assign m_rdata[i]  = best_task;
   end

   // dispatch pulse, slot is free from the next cycle
   assign free_en   = |(m_rvalid & m_rready);
   assign free_slot = best_slot;

endmodule

`default_nettype wire

//--- rtl/task_unit.sv
// task unit top; global timestamp order, a waiting task of one type stalls all other types
`timescale 1ns/100ps
`default_nettype none

`include "task_unit_cfg.svh"

module task_unit (
   input  logic                             clk,
   input  logic                             reset,

   // producer write port
   input  logic                             s_wvalid,
   output logic                             s_wready,
   input  swarm::tq_elem_s                  s_wdata,

   // one read port per task type
   output logic [0:`N_TASK_TYPES-1]         m_rvalid,
   input  logic [0:`N_TASK_TYPES-1]         m_rready,
   output swarm::task_t [0:`N_TASK_TYPES-1] m_rdata
);

   // store requests and grants
   swarm::mem_req_s      enq_req;
   swarm::mem_req_s      scan_req;
   logic                 enq_grant;
   logic                 scan_grant;
   swarm::task_t         rdata;

   // slot bookkeeping
   logic [`TQ_SLOTS-1:0] occupancy;
   logic                 free_en;
   swarm::slot_t         free_slot;

   // engine coupling
   logic                 hold;
   logic                 enq_done;

   task_enqueue u_task_enqueue (
      .clk       (clk),
      .reset     (reset),
      .s_wvalid  (s_wvalid),
      .s_wready  (s_wready),
      .s_wdata   (s_wdata),
      .occupancy (occupancy),
      .hold      (hold),
      .enq_req   (enq_req),
      .enq_grant (enq_grant),
      .enq_done  (enq_done)
   );

   task_min_scan u_task_min_scan (
      .clk        (clk),
      .reset      (reset),
      .occupancy  (occupancy),
      .enq_done   (enq_done),
      .scan_req   (scan_req),
      .scan_grant (scan_grant),
      .rdata      (rdata),
      .free_en    (free_en),
      .free_slot  (free_slot),
      .hold       (hold),
      .m_rvalid   (m_rvalid),
      .m_rready   (m_rready),
      .m_rdata    (m_rdata)
   );

   task_store_arbiter u_task_store_arbiter (
      .clk        (clk),
      .reset      (reset),
      .enq_req    (enq_req),
      .scan_req   (scan_req),
      .free_en    (free_en),
      .free_slot  (free_slot),
      .enq_grant  (enq_grant),
      .scan_grant (scan_grant),
      .rdata      (rdata),
      .occupancy  (occupancy)
   );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
// free running clock and power-on reset; reset drops on a falling edge
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
   parameter real PERIOD       = 4.0,
   parameter int  RESET_CYCLES = 10
) (
   output logic clk,
   output logic reset
);

   initial clk = 1'b0;

   always #(PERIOD / 2.0) clk = ~clk;

   // held for RESET_CYCLES rising edges
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

//--- bench/task_unit_checker.sv
// reference model of the slot queue; assumes writes and dispatches never fall in one cycle
`timescale 1ns/100ps
`default_nettype none

`include "task_unit_cfg.svh"

module task_unit_checker (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             s_wvalid,
   input  logic                             s_wready,
   input  swarm::tq_elem_s                  s_wdata,
   input  logic [0:`N_TASK_TYPES-1]         m_rvalid,
   input  logic [0:`N_TASK_TYPES-1]         m_rready,
   input  swarm::task_t [0:`N_TASK_TYPES-1] m_rdata,
   // error counts: reset, ordering, routing, full, hold
   output int                               errs [5],
   output int                               accepted,
   output int                               dispatched,
   output int                               model_count
);

   // mirrored slot array
   logic         occ  [`TQ_SLOTS];
   swarm::task_t slot [`TQ_SLOTS];

   int           err_cnt [5] = '{default: 0};
   int           n_acc = 0;
   int           n_disp = 0;
   int           n_model = 0;
   int           post_rst = 0;

   // last cycle's stalled winner per port
   logic         stalled   [`N_TASK_TYPES] = '{default: 1'b0};
   swarm::task_t stall_val [`N_TASK_TYPES];

   assign errs        = err_cnt;
   assign accepted    = n_acc;
   assign dispatched  = n_disp;
   assign model_count = n_model;

   initial begin
      for (int k = 0; k < `TQ_SLOTS; k++) begin
         occ[k] = 1'b0;
      end
   end

   // smallest timestamp, lower slot keeps a tie; -1 when empty
   function automatic int min_slot();
      int best;
      best = -1;
      for (int k = 0; k < `TQ_SLOTS; k++) begin
         if (occ[k] && (best < 0 || slot[k].ts < slot[best].ts)) begin
            best = k;
         end
      end
      return best;
   endfunction

   function automatic int lowest_free();
      for (int k = 0; k < `TQ_SLOTS; k++) begin
         if (!occ[k]) begin
            return k;
         end
      end
      return -1;
   endfunction

   always @(posedge clk) begin
      int w;
      int f;
      int nvalid;
      if (reset) begin
         if (s_wready || (|m_rvalid)) begin
            $display("Fail reset: expected s_wready 0 m_rvalid 0, actual %b %b",
                     s_wready, m_rvalid);
            err_cnt[0]++;
         end
      end else begin
         post_rst++;
         if (post_rst == 2 && !s_wready) begin
            $display("Fail reset: expected s_wready 1, actual 0");
            err_cnt[0]++;
         end
         nvalid = 0;
         for (int i = 0; i < `N_TASK_TYPES; i++) begin
            if (m_rvalid[i]) begin
               nvalid++;
               // port has to match the ttype of the model's winner
               w = min_slot();
               if (w >= 0 && (slot[w].ttype != `TTYPE_W'(i) ||
                              m_rdata[i].ttype != slot[w].ttype)) begin
                  $display("Fail routing: expected port %0d, actual port %0d ttype %0d",
                           slot[w].ttype, i, m_rdata[i].ttype);
                  err_cnt[2]++;
               end
            end
            // a stalled winner must stay put
            if (stalled[i] && (!m_rvalid[i] || m_rdata[i] != stall_val[i])) begin
               $display("Fail hold: expected %h, actual %h", stall_val[i], m_rdata[i]);
               err_cnt[4]++;
            end
            stalled[i]   = m_rvalid[i] & ~m_rready[i];
            stall_val[i] = m_rdata[i];
            if (m_rvalid[i] && m_rready[i]) begin
               w = min_slot();
               if (w < 0) begin
                  $display("ordering: dispatch from an empty queue");
                  err_cnt[1]++;
               end else begin
                  if (m_rdata[i].ts != slot[w].ts || m_rdata[i].hint != slot[w].hint) begin
                     $display("Fail ordering: expected ts %0d hint %0d, actual ts %0d hint %0d",
                              slot[w].ts, slot[w].hint, m_rdata[i].ts, m_rdata[i].hint);
                     err_cnt[1]++;
                  end
                  occ[w] = 1'b0;
                  n_model--;
               end
               n_disp++;
            end
         end
         if (nvalid > 1) begin
            $display("routing: more than one read valid at once");
            err_cnt[2]++;
         end
         if (s_wvalid && s_wready) begin
            if (|m_rvalid) begin
               $display("hold: write accepted while a winner is presented");
               err_cnt[4]++;
            end
            f = lowest_free();
            if (f < 0) begin
               $display("full: write accepted with all slots occupied");
               err_cnt[3]++;
            end else begin
               occ[f]        = 1'b1;
               slot[f].ttype = s_wdata.ttype;
               slot[f].ts    = s_wdata.ts;
               slot[f].hint  = s_wdata.hint;
               n_model++;
            end
            n_acc++;
         end
      end
   end

endmodule

`default_nettype wire

//--- bench/task_unit_tb.sv
// testbench top; full queue test first, then seeded random traffic and a drain
`timescale 1ns/100ps
`default_nettype none

`include "task_unit_cfg.svh"

module task_unit_tb;

   localparam int  N_RANDOM    = 300;
   localparam int  N_OPS       = N_RANDOM + `TQ_SLOTS + 1;
   localparam real WATCHDOG_NS = N_OPS * 40 * 4.0;
   localparam int  WAIT_LIMIT  = 400;

   logic                             clk;
   logic                             reset;
   logic                             s_wvalid;
   logic                             s_wready;
   swarm::tq_elem_s                  s_wdata;
   logic [0:`N_TASK_TYPES-1]         m_rvalid;
   logic [0:`N_TASK_TYPES-1]         m_rready;
   swarm::task_t [0:`N_TASK_TYPES-1] m_rdata;

   int     errs [5];
   int     accepted;
   int     dispatched;
   int     model_count;
   integer seed = 32'hfb86;
   int     attempt = 0;
   int     local_errs = 0;
   int     tests_failed = 0;
   int     total;
   logic   rand_ready = 1'b0;

   tb_clock #(.PERIOD(4.0), .RESET_CYCLES(10)) u_tb_clock (.clk(clk), .reset(reset));

   task_unit u_task_unit (
      .clk      (clk),
      .reset    (reset),
      .s_wvalid (s_wvalid),
      .s_wready (s_wready),
      .s_wdata  (s_wdata),
      .m_rvalid (m_rvalid),
      .m_rready (m_rready),
      .m_rdata  (m_rdata)
   );

   task_unit_checker u_checker (
      .clk         (clk),
      .reset       (reset),
      .s_wvalid    (s_wvalid),
      .s_wready    (s_wready),
      .s_wdata     (s_wdata),
      .m_rvalid    (m_rvalid),
      .m_rready    (m_rready),
      .m_rdata     (m_rdata),
      .errs        (errs),
      .accepted    (accepted),
      .dispatched  (dispatched),
      .model_count (model_count)
   );

   // one clock, readies redrawn on the falling edge in random mode
   task automatic step();
      @(posedge clk);
      @(negedge clk);
      if (rand_ready) begin
         m_rready = `N_TASK_TYPES'($random(seed));
      end
   endtask

   task automatic show(input string name, input int n);
      if (n != 0) begin
         tests_failed++;
      end
      $display("test %s: %s (%0d errors)", name, (n == 0) ? "pass" : "fail", n);
   endtask

   // offers one task and holds it until the handshake
   task automatic send_task(input logic [`TS_W-1:0] ts, input logic [`TTYPE_W-1:0] ttype);
      int  n;
      logic done;
      n = 0;
      done = 1'b0;
      s_wvalid      = 1'b1;
      s_wdata.ts    = ts;
      s_wdata.ttype = ttype;
      s_wdata.hint  = `HINT_W'(attempt);
      attempt++;
      while (!done && n < WAIT_LIMIT) begin
         @(posedge clk);
         done = s_wready;
         @(negedge clk);
         if (rand_ready) begin
            m_rready = `N_TASK_TYPES'($random(seed));
         end
         n++;
      end
      if (!done) begin
         $display("write handshake never completed");
         local_errs++;
      end
      s_wvalid = 1'b0;
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests finished");
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      int n;
      int mark;
      logic seen;
      s_wvalid = 1'b0;
      s_wdata  = '0;
      m_rready = '0;
      wait (reset == 1'b1);
      wait (reset == 1'b0);
      @(negedge clk);
      step();
      step();
      show("reset", errs[0]);

      // fill all slots with nothing drained
      mark = local_errs;
      for (int k = 0; k < `TQ_SLOTS; k++) begin
         send_task(`TS_W'($random(seed) & 8'hff), `TTYPE_W'($random(seed)));
      end
      s_wvalid      = 1'b1;
      s_wdata.ts    = `TS_W'($random(seed) & 8'hff);
      s_wdata.ttype = `TTYPE_W'($random(seed));
      s_wdata.hint  = `HINT_W'(attempt);
      attempt++;
      for (int k = 0; k < 40; k++) begin
         @(posedge clk);
         if (s_wready) begin
            $display("Fail full: expected s_wready 0, actual 1");
            local_errs++;
         end
         @(negedge clk);
      end
      // let exactly one winner go
      m_rready = '1;
      seen = 1'b0;
      n = 0;
      while (!seen && n < WAIT_LIMIT) begin
         @(posedge clk);
         seen = |(m_rvalid & m_rready);
         @(negedge clk);
         n++;
      end
      m_rready = '0;
      seen = 1'b0;
      n = 0;
      while (!seen && n < WAIT_LIMIT) begin
         @(posedge clk);
         seen = s_wready;
         @(negedge clk);
         n++;
      end
      if (!seen) begin
         $display("full: the held write was not accepted after a dispatch");
         local_errs++;
      end
      s_wvalid = 1'b0;
      show("full", errs[3] + local_errs - mark);

      // random traffic, three writes in four attempts
      mark = local_errs;
      rand_ready = 1'b1;
      for (int k = 0; k < N_RANDOM; k++) begin
         if (($random(seed) & 3) != 0) begin
            send_task(`TS_W'($random(seed) & 8'hff), `TTYPE_W'($random(seed)));
         end else begin
            step();
         end
      end
      show("ordering", errs[1]);
      show("routing", errs[2]);
      show("hold", errs[4]);

      // drain with every port ready
      rand_ready = 1'b0;
      m_rready = '1;
      n = 0;
      while ((model_count != 0 || dispatched != accepted) && n < N_OPS * 40) begin
         step();
         n++;
      end
      for (int k = 0; k < 30; k++) begin
         step();
         if (|m_rvalid) begin
            $display("drain: a read valid rose with the queue empty");
            local_errs++;
         end
      end
      if (model_count != 0 || dispatched != accepted) begin
         $display("Fail drain: expected %0d dispatched, actual %0d", accepted, dispatched);
         local_errs++;
      end
      show("drain", local_errs - mark);

      total = errs[0] + errs[1] + errs[2] + errs[3] + errs[4] + local_errs;
      $display("6 tests, %0d failed, %0d errors, %0d accepted, %0d dispatched",
               tests_failed, total, accepted, dispatched);
      if (total == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/swarm_pkg.sv
rtl/task_store_arbiter.sv
rtl/task_enqueue.sv
rtl/task_min_scan.sv
rtl/task_unit.sv
bench/tb_clock.sv
bench/task_unit_checker.sv
bench/task_unit_tb.sv

//--- Makefile
# Verilator build for the task unit testbench

TOP = task_unit_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)
	verilator --binary --timing -f sources.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)
	verilator --lint-only -f sources.f +incdir+rtl --top-module task_unit

clean:
	rm -rf obj_dir $(LOG)
